/* hw/data_ram.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   req_i,
    input  logic                   we_i,
    input  logic [3:0]             sel_i,
    input  logic [`LSU_RAM_AW-1:0] addr_i,
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    output logic [`LSU_XLEN-1:0]   rdata_o
);

    localparam int NBYTES = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

    // Starts cleared
    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i && we_i) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (sel_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data valid the cycle after the request
    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* hw/dtlb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dtlb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      we_i,
    input  lsu_pkg::tlb_entry_t       entry_i,
    input  logic [`LSU_VPPN_BITS-1:0] vppn_i,
    output logic                      hit_o,
    output lsu_pkg::tlb_entry_t       entry_o
);
    import lsu_pkg::*;

    localparam int IDX_BITS = $clog2(`LSU_TLB_ENTRIES);

    tlb_entry_t            entries [`LSU_TLB_ENTRIES];
    logic [IDX_BITS-1:0]   wr_idx;
    logic [IDX_BITS-1:0]   rd_idx;

    // Direct mapped on the low vppn bits
    assign wr_idx = entry_i.vppn[IDX_BITS-1:0];
    assign rd_idx = vppn_i[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (we_i) begin
            entries[wr_idx] <= entry_i;
        end
    end

    // Combinational lookup with the full vppn as tag
    always_comb begin
        entry_o = entries[rd_idx];
        hit_o   = entry_o.valid && (entry_o.vppn == vppn_i);
    end

endmodule

/* hw/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] lsu_word_t;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LD_B  = 4'd1,
        LD_BU = 4'd2,
        LD_H  = 4'd3,
        LD_HU = 4'd4,
        LD_W  = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8,
        LL    = 4'd9,
        SC    = 4'd10
    } lsu_op_e;

    typedef struct packed {
        logic                      valid;
        logic [`LSU_VPPN_BITS-1:0] vppn;
        logic [`LSU_VPPN_BITS-1:0] ppn;
        logic                      v;
        logic                      d;
        logic [1:0]                plv;
    } tlb_entry_t;

    // One bit per cause, highest first
    typedef struct packed {
        logic pil;
        logic pis;
        logic ppi;
        logic pme;
        logic tlbr;
        logic adem;
    } excp_vec_t;

    typedef struct packed {
        logic      valid;
        lsu_op_e   op;
        excp_vec_t excp;
        logic [1:0] byte_off;
        logic      wreg;
        logic [4:0] waddr;
        lsu_word_t wdata;
        logic      ll_we;
        logic      ll_value;
    } mem1_out_t;

    // LL counts as a load and SC as a store
    function automatic logic op_is_load(lsu_op_e op);
        return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        return op inside {ST_B, ST_H, ST_W, SC};
    endfunction

endpackage

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_i,
    input  lsu_pkg::lsu_op_e    op_i,
    input  lsu_pkg::lsu_word_t  vaddr_i,
    input  lsu_pkg::lsu_word_t  store_data_i,
    input  logic [4:0]          waddr_i,
    input  lsu_pkg::lsu_word_t  wdata_i,
    input  logic                trans_en_i,
    input  logic [1:0]          plv_i,
    input  logic                tlb_we_i,
    input  lsu_pkg::tlb_entry_t tlb_entry_i,
    output logic                res_valid_o,
    output logic                res_wreg_o,
    output logic [4:0]          res_waddr_o,
    output lsu_pkg::lsu_word_t  res_wdata_o,
    output lsu_pkg::excp_vec_t  res_excp_o
);
    import lsu_pkg::*;

    logic [`LSU_VPPN_BITS-1:0] tlb_vppn;
    logic                      tlb_hit;
    tlb_entry_t                tlb_entry;
    logic                      llbit;
    logic                      ram_req;
    logic                      ram_we;
    logic [3:0]                ram_sel;
    logic [`LSU_RAM_AW-1:0]    ram_addr;
    lsu_word_t                 ram_wdata;
    lsu_word_t                 ram_rdata;
    mem1_out_t                 mem1_q;

    dtlb u_dtlb (
        .clk     (clk),
        .rst     (rst),
        .we_i    (tlb_we_i),
        .entry_i (tlb_entry_i),
        .vppn_i  (tlb_vppn),
        .hit_o   (tlb_hit),
        .entry_o (tlb_entry)
    );

    mem1_stage u_mem1 (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .vaddr_i      (vaddr_i),
        .store_data_i (store_data_i),
        .wdata_i      (wdata_i),
        .waddr_i      (waddr_i),
        .trans_en_i   (trans_en_i),
        .plv_i        (plv_i),
        .tlb_hit_i    (tlb_hit),
        .tlb_entry_i  (tlb_entry),
        .tlb_vppn_o   (tlb_vppn),
        .llbit_i      (llbit),
        .ram_req_o    (ram_req),
        .ram_we_o     (ram_we),
        .ram_sel_o    (ram_sel),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .mem1_q_o     (mem1_q)
    );

    data_ram u_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .we_i    (ram_we),
        .sel_i   (ram_sel),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    mem2_stage u_mem2 (
        .clk         (clk),
        .rst         (rst),
        .mem1_q_i    (mem1_q),
        .ram_rdata_i (ram_rdata),
        .llbit_o     (llbit),
        .res_valid_o (res_valid_o),
        .res_wreg_o  (res_wreg_o),
        .res_waddr_o (res_waddr_o),
        .res_wdata_o (res_wdata_o),
        .res_excp_o  (res_excp_o)
    );

endmodule

/* hw/mem1_stage.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem1_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_i,
    input  lsu_pkg::lsu_op_e          op_i,
    input  lsu_pkg::lsu_word_t        vaddr_i,
    input  lsu_pkg::lsu_word_t        store_data_i,
    input  lsu_pkg::lsu_word_t        wdata_i,
    input  logic [4:0]                waddr_i,
    input  logic                      trans_en_i,
    input  logic [1:0]                plv_i,
    input  logic                      tlb_hit_i,
    input  lsu_pkg::tlb_entry_t       tlb_entry_i,
    output logic [`LSU_VPPN_BITS-1:0] tlb_vppn_o,
    input  logic                      llbit_i,
    output logic                      ram_req_o,
    output logic                      ram_we_o,
    output logic [3:0]                ram_sel_o,
    output logic [`LSU_RAM_AW-1:0]    ram_addr_o,
    output lsu_pkg::lsu_word_t        ram_wdata_o,
    output lsu_pkg::mem1_out_t        mem1_q_o
);
    import lsu_pkg::*;

    logic      is_load;
    logic      is_store;
    logic      is_sc;
    logic      chk;
    logic      mem_ok;
    logic      do_store;
    logic [1:0] byte_off;
    lsu_word_t paddr;
    lsu_word_t st_lane;
    logic [3:0] sel_base;
    excp_vec_t excp;
    mem1_out_t nxt;

    assign is_load  = op_is_load(op_i);
    assign is_store = op_is_store(op_i);
    assign is_sc    = (op_i == SC);

    assign tlb_vppn_o = vaddr_i[`LSU_XLEN-1:`LSU_PAGE_BITS];

    // Exceptions only for memory ops under translation
    assign chk = valid_i && trans_en_i && (is_load || is_store);

    assign excp.adem = chk && (plv_i == 2'd3) && vaddr_i[`LSU_XLEN-1];
    assign excp.tlbr = chk && !tlb_hit_i;
    assign excp.pil  = chk && is_load && tlb_hit_i && !tlb_entry_i.v;
    assign excp.pis  = chk && is_store && tlb_hit_i && !tlb_entry_i.v;
    assign excp.ppi  = chk && tlb_hit_i && tlb_entry_i.v && (plv_i > tlb_entry_i.plv);
    assign excp.pme  = chk && is_store && tlb_hit_i && tlb_entry_i.v
                       && (plv_i <= tlb_entry_i.plv) && !tlb_entry_i.d;

    assign paddr = trans_en_i ? {tlb_entry_i.ppn, vaddr_i[`LSU_PAGE_BITS-1:0]} : vaddr_i;
    assign byte_off = paddr[1:0];

    assign mem_ok   = valid_i && !(|excp);
    // SC stores only while the LL bit holds
    assign do_store = is_store && (!is_sc || llbit_i);

    // Access size
    always_comb begin
        case (op_i)
            LD_B, LD_BU, ST_B: begin
                sel_base = 4'b0001;
                st_lane  = {24'b0, store_data_i[7:0]};
            end
            LD_H, LD_HU, ST_H: begin
                sel_base = 4'b0011;
                st_lane  = {16'b0, store_data_i[15:0]};
            end
            default: begin
                sel_base = 4'b1111;
                st_lane  = store_data_i;
            end
        endcase
    end

    assign ram_req_o   = mem_ok && (is_load || do_store);
    assign ram_we_o    = mem_ok && do_store;
    assign ram_sel_o   = sel_base << byte_off;
    assign ram_addr_o  = paddr[`LSU_RAM_AW+1:2];
    assign ram_wdata_o = st_lane << {byte_off, 3'b000};

    always_comb begin
        nxt          = '0;
        nxt.valid    = valid_i;
        nxt.op       = op_i;
        nxt.excp     = excp;
        nxt.byte_off = byte_off;
        nxt.waddr    = waddr_i;
        if (op_i == NOP) begin
            nxt.wreg  = 1'b1;
            nxt.wdata = wdata_i;
        end else if (mem_ok) begin
            // Load data is filled in by mem2
            if (is_load) begin
                nxt.wreg = 1'b1;
            end
            if (op_i == LL) begin
                nxt.ll_we    = 1'b1;
                nxt.ll_value = 1'b1;
            end
            if (is_sc) begin
                nxt.wreg     = 1'b1;
                nxt.wdata    = lsu_word_t'(llbit_i);
                nxt.ll_we    = llbit_i;
                nxt.ll_value = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem1_q_o <= nxt;
        if (rst) begin
            mem1_q_o.valid <= 1'b0;
        end
    end

endmodule

/* hw/mem2_stage.sv */
`timescale 1ns/1ps

module mem2_stage (
    input  logic                clk,
    input  logic                rst,
    input  lsu_pkg::mem1_out_t  mem1_q_i,
    input  lsu_pkg::lsu_word_t  ram_rdata_i,
    output logic                llbit_o,
    output logic                res_valid_o,
    output logic                res_wreg_o,
    output logic [4:0]          res_waddr_o,
    output lsu_pkg::lsu_word_t  res_wdata_o,
    output lsu_pkg::excp_vec_t  res_excp_o
);
    import lsu_pkg::*;

    lsu_word_t shifted;
    lsu_word_t load_val;
    lsu_word_t wdata_d;
    logic      llbit_q;
    logic      llbit_d;

    // Addressed lane down to bit 0
    assign shifted = ram_rdata_i >> {mem1_q_i.byte_off, 3'b000};

    always_comb begin
        case (mem1_q_i.op)
            LD_B:    load_val = {{24{shifted[7]}}, shifted[7:0]};
            LD_BU:   load_val = {24'b0, shifted[7:0]};
            LD_H:    load_val = {{16{shifted[15]}}, shifted[15:0]};
            LD_HU:   load_val = {16'b0, shifted[15:0]};
            default: load_val = shifted;
        endcase
    end

    assign wdata_d = (op_is_load(mem1_q_i.op) && mem1_q_i.wreg) ? load_val : mem1_q_i.wdata;

    // Next-state value goes back so mem1 sees this cycle's update
    assign llbit_d = (mem1_q_i.valid && mem1_q_i.ll_we) ? mem1_q_i.ll_value : llbit_q;
    assign llbit_o = llbit_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            llbit_q     <= 1'b0;
            res_valid_o <= 1'b0;
            res_wreg_o  <= 1'b0;
        end else begin
            llbit_q     <= llbit_d;
            res_valid_o <= mem1_q_i.valid;
            res_wreg_o  <= mem1_q_i.valid && mem1_q_i.wreg;
        end
    end

    always_ff @(posedge clk) begin
        res_waddr_o <= mem1_q_i.waddr;
        res_wdata_o <= wdata_d;
        res_excp_o  <= mem1_q_i.excp;
    end

endmodule

/* include/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Data and address width
`define LSU_XLEN 32

// Direct-mapped data TLB depth as a power of two
`define LSU_TLB_ENTRIES 8

// Data RAM depth in words
`define LSU_RAM_WORDS 1024

// 4 KiB pages
`define LSU_PAGE_BITS 12

`define LSU_VPPN_BITS (`LSU_XLEN - `LSU_PAGE_BITS)

// Word address width of the data RAM
`define LSU_RAM_AW $clog2(`LSU_RAM_WORDS)

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log

/* sim/lsu_sva.sv */
`timescale 1ns/1ps

module mem1_sva (
    input logic                clk,
    input logic                rst,
    input lsu_pkg::lsu_op_e    op_i,
    input lsu_pkg::excp_vec_t  excp_i,
    input logic                req_i,
    input logic                we_i,
    input logic [3:0]          sel_i
);
    import lsu_pkg::*;

    logic load_op;

    assign load_op = op_i inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};

    // Exceptions suppress the access
    req_no_excp: assert property (@(posedge clk) disable iff (rst) req_i |-> (excp_i == '0))
        else $error("RAM request raised with exception vector %b", excp_i);

    req_has_sel: assert property (@(posedge clk) disable iff (rst) req_i |-> (sel_i != 4'b0000))
        else $error("RAM request raised with empty byte enables");

    no_load_write: assert property (@(posedge clk) disable iff (rst) (req_i && we_i) |-> !load_op)
        else $error("RAM write request raised by load op %s", op_i.name());

endmodule

bind mem1_stage mem1_sva u_mem1_sva (
    .clk    (clk),
    .rst    (rst),
    .op_i   (op_i),
    .excp_i (excp),
    .req_i  (ram_req_o),
    .we_i   (ram_we_o),
    .sel_i  (ram_sel_o)
);

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_BASIC    = 48;
    localparam int N_REMAP    = 32;
    localparam int N_DIRECTED = 32;
    localparam int N_STREAM   = 200;
    localparam int TIMEOUT_CYCLES = 2 * (2 + N_BASIC + N_REMAP + N_DIRECTED + N_STREAM) + 100;
    localparam int TLB_IB = $clog2(`LSU_TLB_ENTRIES);

    typedef struct packed {
        logic       wreg;
        logic [4:0] waddr;
        lsu_word_t  wdata;
        excp_vec_t  excp;
        logic [31:0] cyc;
    } exp_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       valid_i;
    lsu_op_e    op_i;
    lsu_word_t  vaddr_i;
    lsu_word_t  store_data_i;
    logic [4:0] waddr_i;
    lsu_word_t  wdata_i;
    logic       trans_en_i;
    logic [1:0] plv_i;
    logic       tlb_we_i;
    tlb_entry_t tlb_entry_i;
    logic       res_valid_o;
    logic       res_wreg_o;
    logic [4:0] res_waddr_o;
    lsu_word_t  res_wdata_o;
    excp_vec_t  res_excp_o;

    // Shadow state of the model
    lsu_word_t  shadow_ram [`LSU_RAM_WORDS];
    tlb_entry_t shadow_tlb [`LSU_TLB_ENTRIES];
    logic       llbit_sh;
    exp_t       exp_q [$];

    logic [31:0] lfsr;
    int cycle = 0;
    int n_issued = 0;
    int n_results = 0;
    int n_checks = 0;
    int mismatch_cnt = 0;
    int fail_cnt = 0;

    lsu_top dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic lsu_word_t rand_bits(input int n);
        lsu_word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic lsu_op_e pick_load();
        lsu_word_t r;
        r = rand_bits(3) % 32'd5;
        case (r[2:0])
            3'd0: return LD_B;
            3'd1: return LD_BU;
            3'd2: return LD_H;
            3'd3: return LD_HU;
            default: return LD_W;
        endcase
    endfunction

    function automatic lsu_op_e pick_store();
        lsu_word_t r;
        r = rand_bits(2) % 32'd3;
        case (r[1:0])
            2'd0: return ST_B;
            2'd1: return ST_H;
            default: return ST_W;
        endcase
    endfunction

    // Size-aligned address in the first sixteen words of the page
    function automatic lsu_word_t pick_addr(input lsu_op_e op, input logic [19:0] page);
        lsu_word_t r;
        logic [1:0] off;
        r = rand_bits(6);
        case (op)
            LD_B, LD_BU, ST_B: off = r[5:4];
            LD_H, LD_HU, ST_H: off = {r[5], 1'b0};
            default: off = 2'b00;
        endcase
        return {page, 6'b0, r[3:0], off};
    endfunction

    function automatic void model_step(input lsu_op_e op, input lsu_word_t va,
                                       input lsu_word_t sd, input logic [4:0] wa,
                                       input lsu_word_t wd, input logic trans,
                                       input logic [1:0] plv);
        tlb_entry_t ent;
        excp_vec_t  e;
        exp_t       x;
        logic       hit;
        logic       ld;
        logic       st;
        lsu_word_t  pa;
        lsu_word_t  word;
        lsu_word_t  lane;
        logic [`LSU_RAM_AW-1:0] widx;
        logic [TLB_IB-1:0]      tidx;
        int off;
        int nbytes;

        tidx = va[`LSU_PAGE_BITS +: TLB_IB];
        ent  = shadow_tlb[tidx];
        hit  = ent.valid && (ent.vppn == va[`LSU_XLEN-1:`LSU_PAGE_BITS]);
        ld   = op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
        st   = op inside {ST_B, ST_H, ST_W, SC};
        e    = '0;
        if (trans && (ld || st)) begin
            e.adem = (plv == 2'd3) && va[31];
            if (!hit) begin
                e.tlbr = 1'b1;
            end else if (!ent.v) begin
                e.pil = ld;
                e.pis = st;
            end else if (plv > ent.plv) begin
                e.ppi = 1'b1;
            end else if (st && !ent.d) begin
                e.pme = 1'b1;
            end
        end
        pa   = trans ? {ent.ppn, va[`LSU_PAGE_BITS-1:0]} : va;
        widx = pa[`LSU_RAM_AW+1:2];
        off  = int'(pa[1:0]);
        case (op)
            LD_B, LD_BU, ST_B: nbytes = 1;
            LD_H, LD_HU, ST_H: nbytes = 2;
            default: nbytes = 4;
        endcase

        x.excp  = e;
        x.waddr = wa;
        x.wreg  = 1'b0;
        x.wdata = '0;
        x.cyc   = cycle;
        if (op == NOP) begin
            x.wreg  = 1'b1;
            x.wdata = wd;
        end else if (e == '0) begin
            word = shadow_ram[widx];
            lane = word >> (8 * off);
            case (op)
                LD_B:  x.wdata = {{24{lane[7]}}, lane[7:0]};
                LD_BU: x.wdata = {24'b0, lane[7:0]};
                LD_H:  x.wdata = {{16{lane[15]}}, lane[15:0]};
                LD_HU: x.wdata = {16'b0, lane[15:0]};
                LD_W:  x.wdata = word;
                LL: begin
                    x.wdata  = word;
                    llbit_sh = 1'b1;
                end
                SC: begin
                    x.wdata = {31'b0, llbit_sh};
                    if (llbit_sh) begin
                        shadow_ram[widx] = sd;
                        llbit_sh = 1'b0;
                    end
                end
                ST_B, ST_H, ST_W: begin
                    for (int b = 0; b < nbytes; b++) begin
                        shadow_ram[widx][8*(off+b) +: 8] = sd[8*b +: 8];
                    end
                end
                default: ;
            endcase
            x.wreg = ld || (op == SC);
        end
        exp_q.push_back(x);
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_waddr(input string name, input logic [4:0] got, input logic [4:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_word(input string name, input lsu_word_t got, input lsu_word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_excp(input string name, input excp_vec_t got, input excp_vec_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic print_summary();
        $display("Results %0d of %0d, checks %0d, mismatches %0d, other errors %0d",
                 n_results, n_issued, n_checks, mismatch_cnt, fail_cnt);
    endtask

    task automatic issue_op(input lsu_op_e op, input lsu_word_t va, input lsu_word_t sd,
                            input logic trans, input logic [1:0] plv);
        lsu_word_t  r;
        lsu_word_t  wd;
        logic [4:0] wa;
        r  = rand_bits(5);
        wa = r[4:0];
        wd = rand_bits(32);
        @(negedge clk);
        valid_i      = 1'b1;
        op_i         = op;
        vaddr_i      = va;
        store_data_i = sd;
        waddr_i      = wa;
        wdata_i      = wd;
        trans_en_i   = trans;
        plv_i        = plv;
        tlb_we_i     = 1'b0;
        model_step(op, va, sd, wa, wd, trans, plv);
        n_issued++;
    endtask

    task automatic fill_tlb(input logic [19:0] vppn, input logic [19:0] ppn, input logic v,
                            input logic d, input logic [1:0] plv);
        tlb_entry_t e;
        e.valid = 1'b1;
        e.vppn  = vppn;
        e.ppn   = ppn;
        e.v     = v;
        e.d     = d;
        e.plv   = plv;
        @(negedge clk);
        valid_i     = 1'b0;
        tlb_we_i    = 1'b1;
        tlb_entry_i = e;
        shadow_tlb[vppn[TLB_IB-1:0]] = e;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            print_summary();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Results are stable at the falling edge
    always @(negedge clk) begin
        exp_t x;
        if (!rst && res_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Result at %0t arrived with no instruction outstanding", $time);
                fail_cnt++;
            end else begin
                x = exp_q.pop_front();
                n_results++;
                if (cycle != x.cyc + 32'd2) begin
                    $display("Result at %0t came %0d cycles after its input instead of 2",
                             $time, cycle - x.cyc);
                    fail_cnt++;
                end
                check_flag("res_wreg_o", res_wreg_o, x.wreg);
                check_waddr("res_waddr_o", res_waddr_o, x.waddr);
                if (x.wreg) begin
                    check_word("res_wdata_o", res_wdata_o, x.wdata);
                end
                check_excp("res_excp_o", res_excp_o, x.excp);
            end
        end
    end

    initial begin
        lsu_word_t   r;
        lsu_word_t   va;
        lsu_word_t   sd;
        lsu_op_e     op;
        logic [19:0] page;
        logic [19:0] pages [8];
        logic        trans;
        logic [1:0]  plv;

        rst          = 1'b1;
        valid_i      = 1'b0;
        op_i         = NOP;
        vaddr_i      = '0;
        store_data_i = '0;
        waddr_i      = '0;
        wdata_i      = '0;
        trans_en_i   = 1'b0;
        plv_i        = 2'd0;
        tlb_we_i     = 1'b0;
        tlb_entry_i  = '0;
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            shadow_ram[i] = '0;
        end
        for (int i = 0; i < `LSU_TLB_ENTRIES; i++) begin
            shadow_tlb[i] = '0;
        end
        llbit_sh = 1'b0;
        lfsr     = 32'd7836;
        // 0x00018 shares index 0 with 0x00010 and misses on the tag
        pages = '{20'h00010, 20'h00021, 20'h00012, 20'h00013,
                  20'h00014, 20'h80015, 20'h00016, 20'h00018};

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Untranslated stores of each width followed by loads
        for (int i = 0; i < N_BASIC; i++) begin
            op = (i < N_BASIC / 2) ? pick_store() : pick_load();
            va = pick_addr(op, 20'h00000);
            sd = rand_bits(32);
            issue_op(op, va, sd, 1'b0, 2'd0);
        end

        // Two virtual pages on one physical page
        fill_tlb(20'h00010, 20'h00abc, 1'b1, 1'b1, 2'd3);
        fill_tlb(20'h00021, 20'h00abc, 1'b1, 1'b1, 2'd3);
        for (int i = 0; i < N_REMAP; i++) begin
            r    = rand_bits(2);
            page = r[0] ? 20'h00021 : 20'h00010;
            op   = r[1] ? pick_store() : pick_load();
            va   = pick_addr(op, page);
            sd   = rand_bits(32);
            issue_op(op, va, sd, 1'b1, 2'd0);
        end

        // One entry per exception cause
        fill_tlb(20'h00012, 20'h00abc, 1'b0, 1'b1, 2'd3);
        fill_tlb(20'h00013, 20'h00abc, 1'b1, 1'b1, 2'd0);
        fill_tlb(20'h00014, 20'h00abc, 1'b1, 1'b0, 2'd3);
        fill_tlb(20'h80015, 20'h00abc, 1'b1, 1'b1, 2'd3);
        issue_op(ST_W, 32'h00010040, 32'h11223344, 1'b1, 2'd0);
        issue_op(ST_W, 32'h00012040, 32'hdeadbeef, 1'b1, 2'd0);
        issue_op(LD_W, 32'h00012040, 32'h0, 1'b1, 2'd0);
        issue_op(ST_W, 32'h00013040, 32'hdeadbeef, 1'b1, 2'd1);
        issue_op(LD_H, 32'h00013040, 32'h0, 1'b1, 2'd3);
        issue_op(ST_B, 32'h00014040, 32'hdeadbeef, 1'b1, 2'd0);
        issue_op(LD_W, 32'h00014040, 32'h0, 1'b1, 2'd0);
        issue_op(SC, 32'h00014040, 32'hdeadbeef, 1'b1, 2'd0);
        issue_op(LL, 32'h00016040, 32'h0, 1'b1, 2'd0);
        issue_op(ST_W, 32'h80015040, 32'hdeadbeef, 1'b1, 2'd3);
        issue_op(ST_H, 32'h80016040, 32'hdeadbeef, 1'b1, 2'd3);
        issue_op(LD_W, 32'h00010040, 32'h0, 1'b1, 2'd0);
        issue_op(NOP, 32'h80016040, 32'h0, 1'b1, 2'd3);
        issue_op(SC, 32'h00010040, 32'hdeadbeef, 1'b1, 2'd0);
        issue_op(LD_W, 32'h00010040, 32'h0, 1'b1, 2'd0);

        // LL and SC back to back
        issue_op(LL, 32'h00000100, 32'h0, 1'b0, 2'd0);
        issue_op(SC, 32'h00000100, 32'hcafef00d, 1'b0, 2'd0);
        issue_op(SC, 32'h00000100, 32'h0badbeef, 1'b0, 2'd0);
        issue_op(LD_W, 32'h00000100, 32'h0, 1'b0, 2'd0);
        issue_op(SC, 32'h00000100, 32'h0badbeef, 1'b0, 2'd0);
        issue_op(LL, 32'h00000100, 32'h0, 1'b0, 2'd0);
        issue_op(SC, 32'h00000100, 32'h12345678, 1'b0, 2'd0);
        issue_op(LD_W, 32'h00000100, 32'h0, 1'b0, 2'd0);

        // Mixed stream of one op per cycle
        for (int i = 0; i < N_STREAM; i++) begin
            r     = rand_bits(4) % 32'd11;
            op    = lsu_op_e'(r[3:0]);
            r     = rand_bits(6);
            trans = r[0];
            page  = pages[r[3:1]];
            plv   = r[5:4];
            va    = pick_addr(op, page);
            sd    = rand_bits(32);
            issue_op(op, va, sd, trans, plv);
        end

        @(negedge clk);
        valid_i = 1'b0;
        repeat (3) @(negedge clk);
        if (n_results != n_issued) begin
            $display("Only %0d of %0d results arrived", n_results, n_issued);
            fail_cnt++;
        end
        print_summary();
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/lsu_pkg.sv
hw/dtlb.sv
hw/mem1_stage.sv
hw/data_ram.sv
hw/mem2_stage.sv
hw/lsu_top.sv
sim/lsu_sva.sv
sim/lsu_tb.sv
